// File: verilog/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    // CP0 register numbers, select 0 only
    localparam logic [4:0] reg_badvaddr = 5'd8;
    localparam logic [4:0] reg_count    = 5'd9;
    localparam logic [4:0] reg_compare  = 5'd11;
    localparam logic [4:0] reg_status   = 5'd12;
    localparam logic [4:0] reg_cause    = 5'd13;
    localparam logic [4:0] reg_epc      = 5'd14;

    // ExcCode values
    localparam logic [4:0] exc_int  = 5'd0;  // Interrupt
    localparam logic [4:0] exc_adel = 5'd4;  // Address error on load or fetch
    localparam logic [4:0] exc_ades = 5'd5;  // Address error on store
    localparam logic [4:0] exc_sys  = 5'd8;  // Syscall
    localparam logic [4:0] exc_bp   = 5'd9;  // Breakpoint
    localparam logic [4:0] exc_ri   = 5'd10; // Reserved instruction
    localparam logic [4:0] exc_ov   = 5'd12; // Arithmetic overflow

    // Bev is always 1, so all exceptions share the boot vector
    localparam logic [31:0] exc_vector = 32'hbfc0_0380;

    localparam logic [31:0] status_reset = 32'h0040_0000; // Only Bev set

    // Status, register 12
    typedef struct packed {
        logic [8:0] zero_0;  // [31:23]
        logic       bev;     // [22]
        logic [5:0] zero_1;  // [21:16]
        logic [7:0] im;      // [15:8]
        logic [5:0] zero_2;  // [7:2]
        logic       exl;     // [1]
        logic       ie;      // [0]
    } status_t;

    // Cause, register 13
    typedef struct packed {
        logic        bd;       // [31]
        logic        ti;       // [30]
        logic [13:0] zero_0;   // [29:16]
        logic [7:0]  ip;       // [15:8], IP7..IP2 are hardware lines
        logic        zero_1;   // [7]
        logic [4:0]  exc_code; // [6:2]
        logic [1:0]  zero_2;   // [1:0]
    } cause_t;

endpackage

`default_nettype wire

// File: verilog/cp0_timer.sv
`default_nettype none

module cp0_timer (
    input  logic        clk,
    input  logic        reset,
    input  logic        count_we,
    input  logic        compare_we,
    input  logic [31:0] wdata,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        ti
);

    logic half;      // Count advances when this is set
    logic count_upd; // Count changed at the last edge

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count     <= '0;
            half      <= 1'b0;
            count_upd <= 1'b0;
        end else begin
            half <= ~half;
            if (count_we)
                count <= wdata; // Software write wins over the tick
            else if (half)
                count <= count + 32'd1;
            count_upd <= count_we | half;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            compare <= '0;
            ti      <= 1'b0;
        end else begin
            if (compare_we)
                compare <= wdata;
            // Writing Compare acknowledges the timer interrupt
            if (compare_we)
                ti <= 1'b0;
            else if (count_upd && count == compare)
                ti <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cp0_regs.sv
`default_nettype none

module cp0_regs (
    input  logic             clk,
    input  logic             reset,
    input  logic [5:0]       hw_int,
    input  logic             ti,
    input  logic [31:0]      count,
    input  logic [31:0]      compare,

    // mtc0 / mfc0
    input  logic             mtc0_we,
    input  logic [4:0]       cp0_addr,
    input  logic [31:0]      cp0_wdata,
    output logic [31:0]      cp0_rdata,

    // Updates from the exception controller
    input  logic             exc_take,
    input  logic             exc_bd,
    input  logic             exc_badvaddr_we,
    input  logic             eret_take,
    input  logic [4:0]       exc_code,
    input  logic [31:0]      exc_epc,
    input  logic [31:0]      exc_badvaddr,

    output cp0_pkg::status_t status,
    output cp0_pkg::cause_t  cause,
    output logic [31:0]      epc
);

    logic [31:0] badvaddr;
    logic        wr_status;
    logic        wr_cause;
    logic        wr_epc;

    assign wr_status = mtc0_we && cp0_addr == cp0_pkg::reg_status;
    assign wr_cause  = mtc0_we && cp0_addr == cp0_pkg::reg_cause;
    assign wr_epc    = mtc0_we && cp0_addr == cp0_pkg::reg_epc;

    // Status: only IM, EXL and IE are writable
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            status <= cp0_pkg::status_reset;
        end else begin
            if (exc_take) begin
                status.exl <= 1'b1;
            end else if (eret_take) begin
                status.exl <= 1'b0;
            end else if (wr_status) begin
                status.im  <= cp0_wdata[15:8];
                status.exl <= cp0_wdata[1];
                status.ie  <= cp0_wdata[0];
            end
        end
    end

    // Cause
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cause <= '0;
        end else begin
            // Hardware lines sampled every cycle, timer shares IP7
            cause.ti      <= ti;
            cause.ip[7:2] <= {hw_int[5] | ti, hw_int[4:0]};
            if (exc_take) begin
                cause.exc_code <= exc_code;
                if (!status.exl)
                    cause.bd <= exc_bd; // Nested exception keeps BD
            end else if (wr_cause) begin
                cause.ip[1:0] <= cp0_wdata[9:8]; // Software interrupts
            end
        end
    end

    // EPC
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            epc <= '0;
        end else begin
            if (exc_take) begin
                if (!status.exl)
                    epc <= exc_epc;
            end else if (wr_epc) begin
                epc <= cp0_wdata;
            end
        end
    end

    // BadVAddr, read-only to software
    always_ff @(posedge clk, posedge reset) begin
        if (reset)
            badvaddr <= '0;
        else if (exc_take && exc_badvaddr_we)
            badvaddr <= exc_badvaddr;
    end

    // mfc0 read port
    always_comb begin
        case (cp0_addr)
            cp0_pkg::reg_badvaddr: cp0_rdata = badvaddr;
            cp0_pkg::reg_count:    cp0_rdata = count;
            cp0_pkg::reg_compare:  cp0_rdata = compare;
            cp0_pkg::reg_status:   cp0_rdata = status;
            cp0_pkg::reg_cause:    cp0_rdata = cause;
            cp0_pkg::reg_epc:      cp0_rdata = epc;
            default:               cp0_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/exc_ctrl.sv
`default_nettype none

module exc_ctrl (
    input  logic             clk,
    input  logic             reset,

    // Commit port
    input  logic             commit_valid,
    input  logic             commit_bd,
    input  logic             commit_exc,
    input  logic             commit_eret,
    input  logic [31:0]      commit_pc,
    input  logic [31:0]      commit_badvaddr,
    input  logic [4:0]       commit_exc_code,

    input  cp0_pkg::status_t status,
    input  cp0_pkg::cause_t  cause,
    input  logic [31:0]      epc,

    // Register updates
    output logic             exc_take,
    output logic             exc_bd,
    output logic             exc_badvaddr_we,
    output logic             eret_take,
    output logic [4:0]       exc_code,
    output logic [31:0]      exc_epc,
    output logic [31:0]      exc_badvaddr,

    output logic             flush,
    output logic [31:0]      redirect_pc
);

    typedef enum logic {
        run,
        redirect
    } state_t;

    state_t state;
    logic   active;      // Commit is looked at this cycle
    logic   int_pending;
    logic   addr_err;

    assign active = state == run && commit_valid;

    assign int_pending = status.ie && !status.exl && |(cause.ip & status.im);

    assign addr_err = commit_exc_code == cp0_pkg::exc_adel ||
                      commit_exc_code == cp0_pkg::exc_ades;

    // Interrupt first, then the instruction's own exception, then eret
    assign exc_take  = active && (int_pending || commit_exc);
    assign eret_take = active && !int_pending && !commit_exc && commit_eret;

    assign exc_code = int_pending ? cp0_pkg::exc_int : commit_exc_code;
    assign exc_bd   = commit_bd;
    assign exc_epc  = commit_bd ? commit_pc - 32'd4 : commit_pc; // Back to the branch

    assign exc_badvaddr_we = !int_pending && commit_exc && addr_err;
    assign exc_badvaddr    = commit_badvaddr;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= run;
        end else begin
            case (state)
                run:      if (exc_take || eret_take) state <= redirect;
                redirect: state <= run; // Pipeline squashed, commit ignored
                default:  state <= run;
            endcase
        end
    end

    // Target captured along with the update
    always_ff @(posedge clk) begin
        if (exc_take)
            redirect_pc <= cp0_pkg::exc_vector;
        else if (eret_take)
            redirect_pc <= epc;
    end

    assign flush = state == redirect;

endmodule

`default_nettype wire

// File: verilog/cp0_top.sv
`default_nettype none

module cp0_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  hw_int,

    input  logic        commit_valid,
    input  logic        commit_bd,
    input  logic        commit_exc,
    input  logic        commit_eret,
    input  logic [31:0] commit_pc,
    input  logic [31:0] commit_badvaddr,
    input  logic [4:0]  commit_exc_code,

    input  logic        mtc0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,

    output logic        flush,
    output logic [31:0] redirect_pc
);

    logic             count_we;
    logic             compare_we;
    logic [31:0]      count;
    logic [31:0]      compare;
    logic             ti;

    cp0_pkg::status_t status;
    cp0_pkg::cause_t  cause;
    logic [31:0]      epc;

    logic             exc_take;
    logic             exc_bd;
    logic             exc_badvaddr_we;
    logic             eret_take;
    logic [4:0]       exc_code;
    logic [31:0]      exc_epc;
    logic [31:0]      exc_badvaddr;

    // Timer registers live outside cp0_regs
    assign count_we   = mtc0_we && cp0_addr == cp0_pkg::reg_count;
    assign compare_we = mtc0_we && cp0_addr == cp0_pkg::reg_compare;

    cp0_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .count_we   (count_we),
        .compare_we (compare_we),
        .wdata      (cp0_wdata),
        .count      (count),
        .compare    (compare),
        .ti         (ti)
    );

    cp0_regs u_regs (
        .clk             (clk),
        .reset           (reset),
        .hw_int          (hw_int),
        .ti              (ti),
        .count           (count),
        .compare         (compare),
        .mtc0_we         (mtc0_we),
        .cp0_addr        (cp0_addr),
        .cp0_wdata       (cp0_wdata),
        .cp0_rdata       (cp0_rdata),
        .exc_take        (exc_take),
        .exc_bd          (exc_bd),
        .exc_badvaddr_we (exc_badvaddr_we),
        .eret_take       (eret_take),
        .exc_code        (exc_code),
        .exc_epc         (exc_epc),
        .exc_badvaddr    (exc_badvaddr),
        .status          (status),
        .cause           (cause),
        .epc             (epc)
    );

    exc_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .commit_valid    (commit_valid),
        .commit_bd       (commit_bd),
        .commit_exc      (commit_exc),
        .commit_eret     (commit_eret),
        .commit_pc       (commit_pc),
        .commit_badvaddr (commit_badvaddr),
        .commit_exc_code (commit_exc_code),
        .status          (status),
        .cause           (cause),
        .epc             (epc),
        .exc_take        (exc_take),
        .exc_bd          (exc_bd),
        .exc_badvaddr_we (exc_badvaddr_we),
        .eret_take       (eret_take),
        .exc_code        (exc_code),
        .exc_epc         (exc_epc),
        .exc_badvaddr    (exc_badvaddr),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

endmodule

`default_nettype wire

// File: test/cp0_tb.sv
`default_nettype none

module cp0_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        valid;
        logic        bd;
        logic        exc;
        logic        eret;
        logic        irq;   // Interrupt expected on this commit
        logic        we;
        logic        chk;   // Compare cp0_rdata this cycle
        logic [4:0]  code;
        logic [4:0]  addr;
        logic [5:0]  hw;
        logic [31:0] pc;
        logic [31:0] bva;
        logic [31:0] wdata;
        logic [31:0] exp;
    } row_t;

    logic        clk;
    logic        reset;
    logic [5:0]  hw_int;
    logic        commit_valid;
    logic        commit_bd;
    logic        commit_exc;
    logic        commit_eret;
    logic [31:0] commit_pc;
    logic [31:0] commit_badvaddr;
    logic [4:0]  commit_exc_code;
    logic        mtc0_we;
    logic [4:0]  cp0_addr;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;
    logic        flush;
    logic [31:0] redirect_pc;

    row_t        rows[$];
    logic [5:0]  hw_now = 6'd0;
    int          cycles = 0;
    int          limit = 1000;

    // Reference model state
    logic        exl_ref;
    logic        flush_ref;
    logic [31:0] epc_ref;
    logic [31:0] redir_ref;
    logic [31:0] count_ref;

    cp0_top dut (
        .clk             (clk),
        .reset           (reset),
        .hw_int          (hw_int),
        .commit_valid    (commit_valid),
        .commit_bd       (commit_bd),
        .commit_exc      (commit_exc),
        .commit_eret     (commit_eret),
        .commit_pc       (commit_pc),
        .commit_badvaddr (commit_badvaddr),
        .commit_exc_code (commit_exc_code),
        .mtc0_we         (mtc0_we),
        .cp0_addr        (cp0_addr),
        .cp0_wdata       (cp0_wdata),
        .cp0_rdata       (cp0_rdata),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit)
            fail_now($sformatf("Timeout: run did not end within %0d cycles", limit));
    end

    task fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else fail_now($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    // Idle row, reads unknown register 0 which must be zero
    function row_t blank_row();
        row_t r;
        r = '0;
        r.chk = 1'b1;
        r.hw = hw_now;
        return r;
    endfunction

    task set_hw(input logic [5:0] v);
        hw_now = v;
    endtask

    task read_row(input logic [4:0] addr, input logic [31:0] exp);
        row_t r;
        r = blank_row();
        r.addr = addr;
        r.exp = exp;
        rows.push_back(r);
    endtask

    task write_row(input logic [4:0] addr, input logic [31:0] data);
        row_t r;
        r = blank_row();
        r.we = 1'b1;
        r.chk = 1'b0;  // Read shows the old value
        r.addr = addr;
        r.wdata = data;
        rows.push_back(r);
    endtask

    task trap_row(input logic [31:0] pc, input logic bd, input logic [4:0] code,
                  input logic [31:0] bva);
        row_t r;
        r = blank_row();
        r.valid = 1'b1;
        r.exc = 1'b1;
        r.pc = pc;
        r.bd = bd;
        r.code = code;
        r.bva = bva;
        rows.push_back(r);
    endtask

    task insn_row(input logic [31:0] pc, input logic irq);
        row_t r;
        r = blank_row();
        r.valid = 1'b1;
        r.pc = pc;
        r.irq = irq;
        rows.push_back(r);
    endtask

    task eret_row(input logic [31:0] pc);
        row_t r;
        r = blank_row();
        r.valid = 1'b1;
        r.eret = 1'b1;
        r.pc = pc;
        rows.push_back(r);
    endtask

    task build_table();
        // Reset values
        read_row(cp0_pkg::reg_status, cp0_pkg::status_reset);
        read_row(cp0_pkg::reg_cause, 32'h0);
        read_row(cp0_pkg::reg_epc, 32'h0);
        read_row(cp0_pkg::reg_count, 32'h0);
        read_row(cp0_pkg::reg_compare, 32'h0);
        // Writable fields and read-only bits
        write_row(cp0_pkg::reg_status, 32'hffff_ffff);
        read_row(cp0_pkg::reg_status, 32'h0040_ff03);
        write_row(cp0_pkg::reg_status, 32'h0);
        write_row(cp0_pkg::reg_cause, 32'hffff_ffff);
        read_row(cp0_pkg::reg_cause, 32'h0000_0300);
        write_row(cp0_pkg::reg_cause, 32'h0);
        write_row(cp0_pkg::reg_epc, 32'h1234_5678);
        read_row(cp0_pkg::reg_epc, 32'h1234_5678);
        write_row(cp0_pkg::reg_count, 32'h0000_0100);
        read_row(cp0_pkg::reg_count, 32'h0);
        read_row(5'd1, 32'h0);
        write_row(cp0_pkg::reg_badvaddr, 32'hdead_beef);
        // Syscall, then eret
        trap_row(32'h0000_1000, 1'b0, cp0_pkg::exc_sys, 32'h0000_5555);
        read_row(cp0_pkg::reg_cause, 32'h0000_0020);
        read_row(cp0_pkg::reg_epc, 32'h0000_1000);
        read_row(cp0_pkg::reg_status, 32'h0040_0002);
        read_row(cp0_pkg::reg_badvaddr, 32'h0);
        eret_row(32'h0000_2000);
        read_row(cp0_pkg::reg_status, 32'h0040_0000);
        // Address error in a delay slot, commit in the flush cycle is dropped
        trap_row(32'h0000_2004, 1'b1, cp0_pkg::exc_adel, 32'h0000_0003);
        trap_row(32'h0000_3000, 1'b0, cp0_pkg::exc_ov, 32'h0);
        read_row(cp0_pkg::reg_cause, 32'h8000_0010);
        read_row(cp0_pkg::reg_epc, 32'h0000_2000);
        read_row(cp0_pkg::reg_badvaddr, 32'h0000_0003);
        // Nested exception keeps EPC and BD
        trap_row(32'h0000_4000, 1'b0, cp0_pkg::exc_ades, 32'h0000_4001);
        read_row(cp0_pkg::reg_cause, 32'h8000_0014);
        read_row(cp0_pkg::reg_epc, 32'h0000_2000);
        read_row(cp0_pkg::reg_badvaddr, 32'h0000_4001);
        eret_row(32'h0000_5000);
        read_row(cp0_pkg::reg_status, 32'h0040_0000);
        // Hardware interrupt on IP2
        set_hw(6'b000001);
        insn_row(32'h0000_6000, 1'b0);   // IE off
        read_row(cp0_pkg::reg_cause, 32'h8000_0414);
        write_row(cp0_pkg::reg_status, 32'h0000_0801);
        insn_row(32'h0000_6004, 1'b0);   // Wrong IM bit
        write_row(cp0_pkg::reg_status, 32'h0000_0403);
        insn_row(32'h0000_6008, 1'b0);   // EXL set
        write_row(cp0_pkg::reg_status, 32'h0000_0401);
        insn_row(32'h0000_600c, 1'b1);
        read_row(cp0_pkg::reg_cause, 32'h0000_0400);
        read_row(cp0_pkg::reg_epc, 32'h0000_600c);
        set_hw(6'b000000);
        eret_row(32'h0000_7000);
        read_row(cp0_pkg::reg_status, 32'h0040_0401);
        // Timer, Count is 0x111 here and reaches Compare six rows later
        write_row(cp0_pkg::reg_compare, 32'h0000_0114);
        write_row(cp0_pkg::reg_status, 32'h0000_8001);
        read_row(cp0_pkg::reg_compare, 32'h0000_0114);
        read_row(cp0_pkg::reg_count, 32'h0);
        read_row(cp0_pkg::reg_cause, 32'h0);
        read_row(cp0_pkg::reg_count, 32'h0);
        read_row(cp0_pkg::reg_cause, 32'h0);
        read_row(cp0_pkg::reg_cause, 32'h0);
        read_row(cp0_pkg::reg_cause, 32'h4000_8000);
        insn_row(32'h0000_8000, 1'b1);
        read_row(cp0_pkg::reg_cause, 32'h4000_8000);
        read_row(cp0_pkg::reg_epc, 32'h0000_8000);
        write_row(cp0_pkg::reg_compare, 32'h0000_0200);
        read_row(cp0_pkg::reg_compare, 32'h0000_0200);
        read_row(cp0_pkg::reg_cause, 32'h0);   // TI acknowledged
        eret_row(32'h0000_9000);
        read_row(cp0_pkg::reg_status, 32'h0040_8001);
        read_row(cp0_pkg::reg_count, 32'h0);
    endtask

    task apply_row(input row_t r);
        hw_int = r.hw;
        commit_valid = r.valid;
        commit_bd = r.bd;
        commit_exc = r.exc;
        commit_eret = r.eret;
        commit_pc = r.pc;
        commit_badvaddr = r.bva;
        commit_exc_code = r.code;
        mtc0_we = r.we;
        cp0_addr = r.addr;
        cp0_wdata = r.wdata;
    endtask

    task check_row(input row_t r);
        check_word("flush", {31'd0, flush_ref}, {31'd0, flush});
        if (flush_ref)
            check_word("redirect_pc", redir_ref, redirect_pc);
        if (r.chk && r.addr == cp0_pkg::reg_count)
            check_word("cp0_rdata", count_ref, cp0_rdata); // Count from the model
        else if (r.chk)
            check_word("cp0_rdata", r.exp, cp0_rdata);
    endtask

    // Effect of the row at the edge that ends its cycle
    task update_model(input row_t r);
        if (flush_ref) begin
            flush_ref = 1'b0; // Squashed commit
        end else if (r.valid && (r.irq || r.exc)) begin
            if (!exl_ref)
                epc_ref = r.bd ? r.pc - 32'd4 : r.pc;
            exl_ref = 1'b1;
            flush_ref = 1'b1;
            redir_ref = cp0_pkg::exc_vector;
        end else if (r.valid && r.eret) begin
            exl_ref = 1'b0;
            flush_ref = 1'b1;
            redir_ref = epc_ref;
        end
        if (r.we && r.addr == cp0_pkg::reg_status)
            exl_ref = r.wdata[1];
        if (r.we && r.addr == cp0_pkg::reg_epc)
            epc_ref = r.wdata;
    endtask

    initial begin
        row_t prev;
        build_table();
        limit = rows.size() + 50;
        clk = 1'b0;
        reset = 1'b1;
        apply_row(blank_row());
        exl_ref = 1'b0;
        flush_ref = 1'b0;
        epc_ref = 32'h0;
        redir_ref = 32'h0;
        count_ref = 32'h0;
        prev = blank_row();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            // Count moves on every second edge after reset release
            if (prev.we && prev.addr == cp0_pkg::reg_count)
                count_ref = prev.wdata;
            else if ((i + 1) % 2 == 0)
                count_ref = count_ref + 32'd1;
            #1 apply_row(rows[i]);
            #6 check_row(rows[i]);
            update_model(rows[i]);
            prev = rows[i];
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: cp0_subsys.f
verilog/cp0_pkg.sv
verilog/cp0_timer.sv
verilog/cp0_regs.sv
verilog/exc_ctrl.sv
verilog/cp0_top.sv
test/cp0_tb.sv
